// ==== gctr_blocks_top.f ====
source/aes_gctr_pkg.sv
source/inc_counter_block.sv
source/gctr_counter_control.sv
source/aes_round.sv
source/aes_round_ladder_xor_data.sv
source/gctr_blocks_top.sv
dv/gctr_blocks_asserts.sv
dv/gctr_blocks_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the GCTR testbench with Verilator, runs it, and checks the log.
# Exits non-zero on a build error, a run error, or a missing pass line.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module gctr_blocks_tb \
    -Mdir "$OBJ_DIR" \
    -f gctr_blocks_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vgctr_blocks_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG_FILE"; then
    exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1

// ==== dv/gctr_blocks_tb.sv ====
/* Self-checking testbench of the two-lane AES-256 GCTR stage.
   Drives seeded random beats, predicts each output with its own AES model, and
   compares data and latency at every o_valid. */

`timescale 1ns/1ps
`default_nettype none

module gctr_blocks_tb;

    import aes_gctr_pkg::*;

    localparam int CLK_PERIOD   = 40;                    // ns.
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_SEED  = 58;
    localparam int LATENCY      = N_ROUNDS / STAGES_BETWEEN_REGS_DEFAULT;
    localparam int TOTAL_BEATS  = 24 + 48 + 48 + 64 + 20;  // Upper bound over all phases.
    localparam int MAX_GAP      = 3;                     // Longest idle run between beats.
    localparam int N_DRAINS     = 9;                     // Pipeline drains incl. final quiet.
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * (1 + MAX_GAP) + N_DRAINS * (LATENCY + 3)
                                   + 2 * RESET_CYCLES + 200;

    logic        i_clock                 = 1'b0;
    logic        i_reset                 = 1'b1;  // Held from time zero.
    logic        i_valid                 = 1'b0;
    logic        i_sop                   = 1'b0;
    data_t       i_plaintext_words_x     = '0;
    round_keys_t i_round_key_vector      = '0;
    block_t      i_initial_counter_block = '0;
    inc_mode_e   i_inc_mode              = INC_32;
    data_t       o_ciphertext_words_y;
    logic        o_valid;

    round_keys_t model_keys    = '0;      // Keys the DUT sees.
    inc_mode_e   model_mode    = INC_32;
    block_t      model_counter = '0;      // Chained counter, cleared by reset.
    int unsigned edge_count    = 0;       // Rising edges so far.
    data_t       expected_data_q [$];     // Scoreboard, oldest first.
    int unsigned expected_edge_q [$];     // Edge that sampled each beat.

    gctr_blocks_top gctr_blocks_top_inst
    (
        .i_clock                 (i_clock),
        .i_reset                 (i_reset),
        .i_valid                 (i_valid),
        .i_sop                   (i_sop),
        .i_plaintext_words_x     (i_plaintext_words_x),
        .i_round_key_vector      (i_round_key_vector),
        .i_initial_counter_block (i_initial_counter_block),
        .i_inc_mode              (i_inc_mode),
        .o_ciphertext_words_y    (o_ciphertext_words_y),
        .o_valid                 (o_valid)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    always @(posedge i_clock)
    begin
        edge_count <= edge_count + 1;
    end

    task automatic stop_on_failure();
        $display("sim failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_equal(input string name, input data_t actual, input data_t expected);
        if (actual !== expected)
        begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            stop_on_failure();
        end
    endtask

    function automatic block_t rand_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic block_t low_mask(input int width);
        block_t mask;
        mask = '1;
        return mask >> (NB_BLOCK - width);  // Ones in the low width bits.
    endfunction

    // Reference increment: only the masked field moves.
    function automatic block_t increment_counter(input block_t blk, input inc_mode_e mode);
        block_t field;
        field = low_mask(32 * (int'(mode) + 1));
        return (blk & ~field) | ((blk + block_t'(1)) & field);
    endfunction

    function automatic byte_t state_byte(input block_t s, input int idx);
        return s[NB_BLOCK-1-NB_BYTE*idx -: NB_BYTE];  // Byte 0 at the top, FIPS-197.
    endfunction

    // SubBytes then ShiftRows, row r taken from column c+r.
    function automatic block_t sub_shift(input block_t s);
        block_t result;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                result[NB_BLOCK-1-NB_BYTE*(4*c+r) -: NB_BYTE] =
                    aes_sbox(state_byte(s, 4 * ((c + r) % 4) + r));
            end
        end
        return result;
    endfunction

    // Circulant {02 03 01 01} per column.
    function automatic block_t mix_columns(input block_t s);
        block_t result;
        byte_t  a [4];
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                a[r] = state_byte(s, 4 * c + r);
            end
            for (int r = 0; r < 4; r++)
            begin
                result[NB_BLOCK-1-NB_BYTE*(4*c+r) -: NB_BYTE] =
                    gf_xtime(a[r]) ^ gf_xtime(a[(r+1)%4]) ^ a[(r+1)%4] ^ a[(r+2)%4] ^ a[(r+3)%4];
            end
        end
        return result;
    endfunction

    function automatic block_t aes256_encrypt(input block_t blk, input round_keys_t keys);
        block_t s;
        s = blk ^ keys[0 +: NB_BLOCK];  // Whitening.
        for (int r = 1; r <= N_ROUNDS; r++)
        begin
            s = sub_shift(s);
            if (r < N_ROUNDS)
            begin
                s = mix_columns(s);  // Final round has none.
            end
            s = s ^ keys[r*NB_BLOCK +: NB_BLOCK];
        end
        return s;
    endfunction

    // New keys and mode; call only with nothing in flight.
    task automatic load_phase_config(input inc_mode_e mode);
        for (int w = 0; w < NB_ROUND_KEYS / 32; w++)
        begin
            model_keys[32*w +: 32] = $urandom();
        end
        model_mode = mode;
        i_round_key_vector <= model_keys;
        i_inc_mode         <= mode;
    endtask

    // One beat on the next edge, predicted and queued.
    task automatic send_beat(input logic sop, input block_t init_ctr);
        data_t  plaintext;
        data_t  expected;
        block_t ctr;
        @(posedge i_clock);
        plaintext = {rand_block(), rand_block()};
        ctr = sop ? init_ctr : model_counter;
        for (int k = 0; k < N_BLOCKS; k++)
        begin
            expected[k*NB_BLOCK +: NB_BLOCK] =
                plaintext[k*NB_BLOCK +: NB_BLOCK] ^ aes256_encrypt(ctr, model_keys);
            ctr = increment_counter(ctr, model_mode);
        end
        model_counter = ctr;  // Next beat continues here.
        expected_data_q.push_back(expected);
        expected_edge_q.push_back(edge_count + 2);  // DUT samples on the following edge.
        i_valid                 <= 1'b1;
        i_sop                   <= sop;
        i_plaintext_words_x     <= plaintext;
        i_initial_counter_block <= init_ctr;
    endtask

    // Idle cycles with junk on the data inputs.
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge i_clock);
            i_valid                 <= 1'b0;
            i_sop                   <= 1'($urandom_range(1));
            i_plaintext_words_x     <= {rand_block(), rand_block()};
            i_initial_counter_block <= rand_block();
        end
    endtask

    task automatic drain_pipeline();
        idle_cycles(1);
        while (expected_data_q.size() != 0)
        begin
            @(posedge i_clock);
        end
    endtask

    task automatic apply_reset();
        @(posedge i_clock);
        i_reset <= 1'b1;
        i_valid <= 1'b0;
        i_sop   <= 1'b0;
        @(posedge i_clock);  // DUT clears here.
        expected_data_q.delete();
        expected_edge_q.delete();
        model_counter = '0;
        repeat (RESET_CYCLES - 1) @(posedge i_clock);
        i_reset <= 1'b0;
    endtask

    // Scoreboard, sampled away from the rising edge.
    always @(negedge i_clock)
    begin
        if (o_valid === 1'b1)
        begin
            if (expected_data_q.size() == 0)
            begin
                $display("Output valid seen with no beat in flight.");
                stop_on_failure();
            end
            else
            begin
                check_equal("o_ciphertext_words_y", o_ciphertext_words_y,
                            expected_data_q.pop_front());
                check_equal("o_valid latency", data_t'(edge_count + 1 - expected_edge_q.pop_front()),
                            data_t'(LATENCY));
            end
        end
    end

    // Bound assertions end the run at their first failure.
    always @(negedge i_clock)
    begin
        if (gctr_blocks_top_inst.gctr_blocks_asserts_inst.failure_count != 0)
        begin
            $display("A bound assertion on the DUT failed.");
            stop_on_failure();
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all beats came back.");
        stop_on_failure();
    end

    initial
    begin
        int n_beats;
        void'($urandom(RANDOM_SEED));
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;

        load_phase_config(INC_32);  // Single-beat packets.
        for (int i = 0; i < 24; i++)
        begin
            send_beat(1'b1, rand_block());
            idle_cycles($urandom_range(MAX_GAP));
        end
        drain_pipeline();

        load_phase_config(INC_32);  // Chaining across beats and idle cycles.
        for (int p = 0; p < 8; p++)
        begin
            n_beats = 2 + $urandom_range(4);
            for (int b = 0; b < n_beats; b++)
            begin
                send_beat(b == 0, rand_block());
                idle_cycles($urandom_range(MAX_GAP));
            end
        end
        drain_pipeline();

        for (int m = 0; m < 4; m++)  // Every mode meets every all-ones field width.
        begin
            load_phase_config(inc_mode_e'(m));
            for (int w = 1; w <= 4; w++)
            begin
                send_beat(1'b1, rand_block() | low_mask(32 * w));
                send_beat(1'b0, rand_block());
                send_beat(1'b0, rand_block());
                idle_cycles($urandom_range(1));
            end
            drain_pipeline();
        end

        load_phase_config(inc_mode_e'($urandom_range(3)));  // Full rate, sparse gaps.
        for (int i = 0; i < 64; i++)
        begin
            send_beat((i == 0) || ($urandom_range(7) == 0), rand_block());
            idle_cycles(($urandom_range(9) < 3) ? $urandom_range(2) : 0);
        end
        drain_pipeline();

        load_phase_config(INC_64);  // Reset with beats in flight.
        for (int i = 0; i < 8; i++)
        begin
            send_beat(i == 0, rand_block());
        end
        apply_reset();
        for (int i = 0; i < 12; i++)
        begin
            send_beat(i == 0, rand_block());
            idle_cycles($urandom_range(1));
        end
        drain_pipeline();
        idle_cycles(LATENCY + 2);  // Nothing may follow.

        if (gctr_blocks_top_inst.gctr_blocks_asserts_inst.failure_count == 0)
        begin
            $display("sim passed");
            $finish;
        end
        else
        begin
            $display("A bound assertion on the DUT failed.");
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

// ==== dv/gctr_blocks_asserts.sv ====
/* Concurrent checks on the GCTR top level, bound to it from this file.
   Covers valid clearing on reset, the fixed latency of valid, and known output data. */

`timescale 1ns/1ps
`default_nettype none

module gctr_blocks_asserts
(
    input wire                       i_clock,
    input wire                       i_reset,
    input wire                       i_valid,               // DUT beat strobe.
    input wire                       i_out_valid,           // DUT o_valid.
    input wire aes_gctr_pkg::data_t  i_ciphertext_words_y   // DUT output data.
);

    import aes_gctr_pkg::*;

    localparam int LATENCY = N_ROUNDS / STAGES_BETWEEN_REGS_DEFAULT;

    int          cycles_since_reset;  // Saturates at LATENCY.
    int unsigned failure_count = 0;   // Failed assertions, read by the testbench.

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            cycles_since_reset <= 0;
        end
        else if (cycles_since_reset < LATENCY)
        begin
            cycles_since_reset <= cycles_since_reset + 1;
        end
    end

    // Valid pipeline empty while in reset and the cycle after.
    a_reset_clears_valid: assert property (@(posedge i_clock) i_reset |=> !i_out_valid)
        else
        begin
            failure_count++;
            $error("o_valid high right after reset");
        end

    // Valid comes out exactly LATENCY edges after it was sampled.
    a_valid_latency: assert property (@(posedge i_clock) disable iff (i_reset)
        (cycles_since_reset >= LATENCY) |-> (i_out_valid == $past(i_valid, LATENCY)))
        else
        begin
            failure_count++;
            $error("o_valid does not follow i_valid at the pipeline latency");
        end

    a_known_data: assert property (@(posedge i_clock) disable iff (i_reset)
        i_out_valid |-> !$isunknown(i_ciphertext_words_y))
        else
        begin
            failure_count++;
            $error("o_ciphertext_words_y has unknown bits while valid");
        end

endmodule

bind gctr_blocks_top gctr_blocks_asserts gctr_blocks_asserts_inst
(
    .i_clock              (i_clock),
    .i_reset              (i_reset),
    .i_valid              (i_valid),
    .i_out_valid          (o_valid),
    .i_ciphertext_words_y (o_ciphertext_words_y)
);

`default_nettype wire

// ==== source/gctr_blocks_top.sv ====
/* Top level of the two-lane AES-256 GCTR stage.
   Counter control feeds one encryption ladder per lane; output after 14 cycles. */

`timescale 1ns/1ps
`default_nettype none

module gctr_blocks_top
(
    input  wire                            i_clock,
    input  wire                            i_reset,
    input  wire                            i_valid,                  // One beat.
    input  wire                            i_sop,                    // Only with i_valid.
    input  wire aes_gctr_pkg::data_t       i_plaintext_words_x,      // Lane k at bit k*128.
    input  wire aes_gctr_pkg::round_keys_t i_round_key_vector,       // Static in flight.
    input  wire aes_gctr_pkg::block_t      i_initial_counter_block,  // Used on sop.
    input  wire aes_gctr_pkg::inc_mode_e   i_inc_mode,               // Static.
    output wire aes_gctr_pkg::data_t       o_ciphertext_words_y,
    output wire                            o_valid
);

    import aes_gctr_pkg::*;

    wire data_t               counter_blocks;  // Per-lane counters, this cycle.
    wire logic [N_BLOCKS-1:0] lane_valid;      // Lanes run in lockstep.

    gctr_counter_control gctr_counter_control_inst
    (
        .i_clock                 (i_clock),
        .i_reset                 (i_reset),
        .i_valid                 (i_valid),
        .i_sop                   (i_sop),
        .i_initial_counter_block (i_initial_counter_block),
        .i_inc_mode              (i_inc_mode),
        .o_counter_blocks        (counter_blocks)
    );

    for (genvar k = 0; k < N_BLOCKS; k++)
    begin : g_lane
        aes_round_ladder_xor_data aes_round_ladder_xor_data_inst
        (
            .i_clock            (i_clock),
            .i_reset            (i_reset),
            .i_valid            (i_valid),
            .i_state            (counter_blocks[k*NB_BLOCK +: NB_BLOCK]),
            .i_data             (i_plaintext_words_x[k*NB_BLOCK +: NB_BLOCK]),
            .i_round_key_vector (i_round_key_vector),
            .o_data             (o_ciphertext_words_y[k*NB_BLOCK +: NB_BLOCK]),
            .o_valid            (lane_valid[k])
        );
    end

    assign o_valid = lane_valid[0];  // Lane 0 speaks for all.

endmodule

`default_nettype wire

// ==== source/aes_round_ladder_xor_data.sv ====
/* Pipelined AES-256 encryption of one counter block, XORed with the plaintext
   carried alongside. Latency is N_ROUNDS / STAGES_BETWEEN_REGS cycles. */

`timescale 1ns/1ps
`default_nettype none

module aes_round_ladder_xor_data
#(
    parameter int STAGES_BETWEEN_REGS = aes_gctr_pkg::STAGES_BETWEEN_REGS_DEFAULT
)
(
    input  wire                            i_clock,
    input  wire                            i_reset,
    input  wire                            i_valid,             // Beat strobe.
    input  wire aes_gctr_pkg::block_t      i_state,             // Counter block.
    input  wire aes_gctr_pkg::block_t      i_data,              // Plaintext block.
    input  wire aes_gctr_pkg::round_keys_t i_round_key_vector,  // Static keys 0..14.
    output wire aes_gctr_pkg::block_t      o_data,              // Ciphertext block.
    output wire                            o_valid              // Aligned with o_data.
);

    import aes_gctr_pkg::*;

    block_t state_chain [N_ROUNDS+1];  // State after round r, registered or not.
    block_t data_chain  [N_ROUNDS+1];  // Plaintext delayed to match.
    logic   valid_chain [N_ROUNDS+1];  // Valid delayed to match.

    // Only divisors of the round count give a whole number of stages.
    if ((N_ROUNDS % STAGES_BETWEEN_REGS) != 0)
    begin : g_bad_stages
        $error("STAGES_BETWEEN_REGS must divide the AES-256 round count");
    end

    // Round 0 is the whitening key add; it shares the first stage with round 1.
    assign state_chain[0] = i_state ^ i_round_key_vector[0 +: NB_BLOCK];
    assign data_chain[0]  = i_data;
    assign valid_chain[0] = i_valid;

    for (genvar r = 1; r <= N_ROUNDS; r++)
    begin : g_round
        block_t round_state;  // Combinational result of round r.

        aes_round aes_round_inst
        (
            .i_state     (state_chain[r-1]),
            .i_round_key (i_round_key_vector[r*NB_BLOCK +: NB_BLOCK]),
            .i_final     (r == N_ROUNDS),  // No MixColumns in round 14.
            .o_state     (round_state)
        );

        if ((r % STAGES_BETWEEN_REGS) == 0)
        begin : g_reg
            // Payload registers, no reset.
            always_ff @(posedge i_clock)
            begin
                state_chain[r] <= round_state;
                data_chain[r]  <= data_chain[r-1];
            end

            // Valid pipeline is control state.
            always_ff @(posedge i_clock)
            begin
                if (i_reset)
                begin
                    valid_chain[r] <= 1'b0;
                end
                else
                begin
                    valid_chain[r] <= valid_chain[r-1];
                end
            end
        end
        else
        begin : g_wire
            assign state_chain[r] = round_state;  // Chained within the stage.
            assign data_chain[r]  = data_chain[r-1];
            assign valid_chain[r] = valid_chain[r-1];
        end
    end

    // Keystream XOR plaintext.
    assign o_data  = state_chain[N_ROUNDS] ^ data_chain[N_ROUNDS];
    assign o_valid = valid_chain[N_ROUNDS];

endmodule

`default_nettype wire

// ==== source/aes_round.sv ====
/* One combinational AES encryption round.
   SubBytes, ShiftRows, MixColumns unless final, then AddRoundKey. */

`timescale 1ns/1ps
`default_nettype none

module aes_round
(
    input  wire aes_gctr_pkg::block_t i_state,      // State in, byte 0 at top.
    input  wire aes_gctr_pkg::block_t i_round_key,  // Key for this round.
    input  wire                       i_final,      // Last round skips MixColumns.
    output wire aes_gctr_pkg::block_t o_state       // State out.
);

    import aes_gctr_pkg::*;

    wire byte_t sub_bytes   [N_BYTES];  // After SubBytes.
    wire byte_t shift_bytes [N_BYTES];  // After ShiftRows.
    wire byte_t mix_bytes   [N_BYTES];  // After MixColumns.

    // Byte b sits in row b%4, column b/4, as in FIPS-197.
    for (genvar b = 0; b < N_BYTES; b++)
    begin : g_byte
        assign sub_bytes[b] = aes_sbox(i_state[NB_BLOCK-1-NB_BYTE*b -: NB_BYTE]);

        // Row r rotates left by r columns.
        assign shift_bytes[b] =
            sub_bytes[(b % N_STATE_ROWS) +
                      N_STATE_ROWS * (((b / N_STATE_ROWS) + (b % N_STATE_ROWS)) % N_STATE_ROWS)];

        // Mixed or plain state, then the round key.
        assign o_state[NB_BLOCK-1-NB_BYTE*b -: NB_BYTE] =
            (i_final ? shift_bytes[b] : mix_bytes[b]) ^
            i_round_key[NB_BLOCK-1-NB_BYTE*b -: NB_BYTE];
    end

    // Column times the fixed matrix {02 03 01 01}.
    for (genvar c = 0; c < N_STATE_ROWS; c++)
    begin : g_mix_column
        wire byte_t col [N_STATE_ROWS];  // Column bytes.
        wire byte_t dbl [N_STATE_ROWS];  // Same bytes times 2.

        for (genvar r = 0; r < N_STATE_ROWS; r++)
        begin : g_row
            assign col[r] = shift_bytes[N_STATE_ROWS*c + r];
            assign dbl[r] = gf_xtime(col[r]);
        end

        // Times 3 is times 2 plus the byte.
        assign mix_bytes[N_STATE_ROWS*c + 0] = dbl[0] ^ dbl[1] ^ col[1] ^ col[2] ^ col[3];
        assign mix_bytes[N_STATE_ROWS*c + 1] = col[0] ^ dbl[1] ^ dbl[2] ^ col[2] ^ col[3];
        assign mix_bytes[N_STATE_ROWS*c + 2] = col[0] ^ col[1] ^ dbl[2] ^ dbl[3] ^ col[3];
        assign mix_bytes[N_STATE_ROWS*c + 3] = dbl[0] ^ col[0] ^ col[1] ^ col[2] ^ dbl[3];
    end

endmodule

`default_nettype wire

// ==== source/gctr_counter_control.sv ====
/* Counter control for the GCTR lanes.
   Builds one counter per lane from the initial or chained counter and keeps the
   chain going across valid beats. */

`timescale 1ns/1ps
`default_nettype none

module gctr_counter_control
(
    input  wire                          i_clock,
    input  wire                          i_reset,
    input  wire                          i_valid,                  // Beat strobe.
    input  wire                          i_sop,                    // Start of packet.
    input  wire aes_gctr_pkg::block_t    i_initial_counter_block,  // Loaded on sop.
    input  wire aes_gctr_pkg::inc_mode_e i_inc_mode,               // Static.
    output wire aes_gctr_pkg::data_t     o_counter_blocks          // Lane k at bit k*128.
);

    import aes_gctr_pkg::*;

    block_t      counter_saved;                // Counter after the last lane of last beat.
    wire block_t counter_chain [N_BLOCKS+1];   // Entry k feeds lane k, last is next beat.

    // First lane restarts on sop, else continues the stream.
    assign counter_chain[0] = i_sop ? i_initial_counter_block : counter_saved;

    for (genvar k = 0; k < N_BLOCKS; k++)
    begin : g_lane
        assign o_counter_blocks[k*NB_BLOCK +: NB_BLOCK] = counter_chain[k];

        // Next lane gets the incremented counter.
        inc_counter_block inc_counter_block_inst
        (
            .i_block (counter_chain[k]),
            .i_mode  (i_inc_mode),
            .o_block (counter_chain[k+1])
        );
    end

    // Keep the follow-on counter for the next beat.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            counter_saved <= '0;
        end
        else if (i_valid)
        begin
            counter_saved <= counter_chain[N_BLOCKS];  // Idle cycles hold it.
        end
    end

endmodule

`default_nettype wire

// ==== source/inc_counter_block.sv ====
/* Counter block increment for GCTR.
   Adds one within the low 32, 64, 96 or 128 bits; upper bits pass unchanged. */

`timescale 1ns/1ps
`default_nettype none

module inc_counter_block
(
    input  wire aes_gctr_pkg::block_t    i_block,  // Current counter block.
    input  wire aes_gctr_pkg::inc_mode_e i_mode,   // Static field width select.
    output aes_gctr_pkg::block_t         o_block   // Next counter block.
);

    import aes_gctr_pkg::*;

    always_comb
    begin
        o_block = i_block;  // Bits above the field stay as they are.
        case (i_mode)
            INC_32:
            begin
                o_block[31:0] = i_block[31:0] + 32'd1;  // Wraps inside 32 bits.
            end
            INC_64:
            begin
                o_block[63:0] = i_block[63:0] + 64'd1;
            end
            INC_96:
            begin
                o_block[95:0] = i_block[95:0] + 96'd1;
            end
            default:
            begin
                o_block = i_block + block_t'(1);  // Full block wrap.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/aes_gctr_pkg.sv ====
/* Shared widths, types and byte functions of the AES-256 GCTR datapath.
   Modules import it in their bodies and use scoped names in their headers. */

`default_nettype none

package aes_gctr_pkg;

    localparam int NB_BLOCK      = 128;                        // Bits per AES block.
    localparam int NB_BYTE       = 8;                          // Bits per byte.
    localparam int N_BYTES       = NB_BLOCK / NB_BYTE;         // Bytes per block.
    localparam int N_STATE_ROWS  = 4;                          // State is 4 x 4 bytes.
    localparam int N_ROUNDS      = 14;                         // AES-256 round count.
    localparam int N_BLOCKS      = 2;                          // Lanes per beat.
    localparam int NB_DATA       = N_BLOCKS * NB_BLOCK;        // Data bits per beat.
    localparam int NB_ROUND_KEYS = (N_ROUNDS + 1) * NB_BLOCK;  // All round keys.
    localparam int NB_INC_MODE   = 2;                          // Increment mode width.

    // Rounds per pipeline stage; must divide N_ROUNDS.
    localparam int STAGES_BETWEEN_REGS_DEFAULT = 1;

    localparam int           SBOX_ENTRIES = 256;               // One entry per byte value.
    localparam logic [7:0]   GF_POLY_LOW  = 8'h1B;             // Low bits of x^8+x^4+x^3+x+1.

    typedef logic [NB_BLOCK-1:0]      block_t;       // One 128-bit block.
    typedef logic [NB_DATA-1:0]       data_t;        // One beat, lane k at bit k*128.
    typedef logic [NB_ROUND_KEYS-1:0] round_keys_t;  // Key k at bit k*128, key 0 whitens.
    typedef logic [NB_BYTE-1:0]       byte_t;        // One byte.

    // Width of the counter field that takes the increment.
    typedef enum logic [NB_INC_MODE-1:0]
    {
        INC_32  = 2'd0,
        INC_64  = 2'd1,
        INC_96  = 2'd2,
        INC_128 = 2'd3
    } inc_mode_e;

    // Forward S-box, entry 0 in the top byte.
    localparam logic [SBOX_ENTRIES*NB_BYTE-1:0] SBOX_TABLE =
    {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // SubBytes lookup for one byte.
    function automatic byte_t aes_sbox(input byte_t i_byte);
        int entry;
        entry = SBOX_ENTRIES - 1 - int'(i_byte);  // Table is stored top down.
        return SBOX_TABLE[entry*NB_BYTE +: NB_BYTE];
    endfunction

    // Multiply by x in GF(2^8).
    function automatic byte_t gf_xtime(input byte_t i_byte);
        byte_t shifted;
        shifted = {i_byte[NB_BYTE-2:0], 1'b0};
        return i_byte[NB_BYTE-1] ? (shifted ^ GF_POLY_LOW) : shifted;  // Reduce on carry out.
    endfunction

endpackage

`default_nettype wire
